// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dispatch_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
verilog/procyon_pkg.sv
verilog/rob_if.sv
verilog/decode_rename.sv
verilog/register_map.sv
verilog/reorder_buffer.sv
verilog/commit_unit.sv
verilog/dispatch_top.sv
testbench/dispatch_assertions.sv
testbench/dispatch_tb.sv

// ==== testbench/dispatch_assertions.sv ====
/*
 * Concurrent checks on the ROB, bound into reorder_buffer.
 * Sampled on the rising edge and disabled while reset is asserted.
 */
`default_nettype none

module dispatch_assertions
    import procyon_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic [ROB_TAG_WIDTH:0] i_count,
    input  logic                   i_enq_en,
    input  logic                   i_full,
    input  logic                   i_pop,
    input  logic                   i_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Occupancy stays within the buffer
    assert property (@(posedge clk) disable iff (!i_rst_n) int'(i_count) <= ROB_DEPTH)
        else $error("ROB occupancy %0d exceeds the depth", i_count);

    // No acceptance while full, so no enqueue one cycle later
    assert property (@(posedge clk) disable iff (!i_rst_n) i_full |=> !i_enq_en)
        else $error("ROB enqueue after a cycle with full high");

    assert property (@(posedge clk) disable iff (!i_rst_n) i_pop |-> i_valid)
        else $error("ROB pop while the head is not valid");

endmodule

bind reorder_buffer dispatch_assertions u_rob_assertions (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_count  (count),
    .i_enq_en (enq.en),
    .i_full   (o_full),
    .i_pop    (deq.pop),
    .i_valid  (deq.valid)
);

`default_nettype wire

// ==== testbench/dispatch_tb.sv ====
/*
 * Table-driven testbench for dispatch_top with a cycle-level reference model.
 * Inputs change 1 ns after the rising edge; outputs are checked 1 ns after it.
 * A stalled row is not presented again; later rows carry on with new instructions.
 */
`default_nettype none

module dispatch_tb
    import procyon_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        string                    name;
        logic [ADDR_WIDTH-1:0]    pc;
        logic [DATA_WIDTH-1:0]    insn;
        logic                     valid;
        logic                     rs_stall;
        logic                     ready;
        logic                     ready_rnd;
        logic                     flush;
        rob_op_e                  kind;
        logic [REG_IDX_WIDTH-1:0] erd;
        logic                     use1;
        logic                     use2;
    } step_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    pc;
        rob_op_e                  op;
        logic [REG_IDX_WIDTH-1:0] rd;
        logic [ROB_TAG_WIDTH-1:0] tag;
    } rob_entry_t;

    logic                     clk;
    logic                     rst_n;
    logic                     flush;
    logic                     rs_stall;
    logic [ADDR_WIDTH-1:0]    dispatch_pc;
    logic [DATA_WIDTH-1:0]    dispatch_insn;
    logic                     dispatch_valid;
    logic                     dispatch_stall;
    logic                     rs_en;
    opcode_e                  rs_opcode;
    logic [ADDR_WIDTH-1:0]    rs_pc;
    logic [DATA_WIDTH-1:0]    rs_insn;
    logic [ROB_TAG_WIDTH-1:0] rs_dst_tag;
    logic [ROB_TAG_WIDTH-1:0] rs_src_tag [2];
    logic                     rs_src_rdy [2];
    logic                     commit_ready;
    logic                     commit_valid;
    logic [ADDR_WIDTH-1:0]    commit_pc;
    rob_op_e                  commit_op;
    logic [REG_IDX_WIDTH-1:0] commit_rdest;
    logic [ROB_TAG_WIDTH-1:0] commit_tag;

    // Stimulus table and the controls that new rows pick up
    step_t table_q [$];
    logic  table_ready = 1'b0;
    logic  cur_ready;
    logic  cur_rnd;
    logic  cur_stall;
    int    err_cnt = 0;
    int    chk_cnt = 0;

    // Reference model state
    logic                     m_busy [2**REG_IDX_WIDTH];
    logic [ROB_TAG_WIDTH-1:0] m_tag [2**REG_IDX_WIDTH];
    logic [ROB_TAG_WIDTH-1:0] m_tail;
    logic                     m_enq_pending;
    rob_entry_t               m_pending;
    rob_entry_t               m_rob [$];
    logic                     m_slot_valid;
    rob_entry_t               m_slot;
    logic                     m_rs_en;
    logic [6:0]               e_opcode;
    logic [ADDR_WIDTH-1:0]    e_pc;
    logic [DATA_WIDTH-1:0]    e_insn;
    logic [ROB_TAG_WIDTH-1:0] e_dst_tag;
    logic [ROB_TAG_WIDTH-1:0] e_src_tag [2];
    logic                     e_src_rdy [2];

    dispatch_top uut (
        .clk              (clk),
        .i_rst_n          (rst_n),
        .i_flush          (flush),
        .i_rs_stall       (rs_stall),
        .i_dispatch_pc    (dispatch_pc),
        .i_dispatch_insn  (dispatch_insn),
        .i_dispatch_valid (dispatch_valid),
        .o_dispatch_stall (dispatch_stall),
        .o_rs_en          (rs_en),
        .o_rs_opcode      (rs_opcode),
        .o_rs_pc          (rs_pc),
        .o_rs_insn        (rs_insn),
        .o_rs_dst_tag     (rs_dst_tag),
        .o_rs_src_tag     (rs_src_tag),
        .o_rs_src_rdy     (rs_src_rdy),
        .i_commit_ready   (commit_ready),
        .o_commit_valid   (commit_valid),
        .o_commit_pc      (commit_pc),
        .o_commit_op      (commit_op),
        .o_commit_rdest   (commit_rdest),
        .o_commit_tag     (commit_tag)
    );

    always #5 clk = ~clk;

    function automatic logic [DATA_WIDTH-1:0] encode(opcode_e opc, int rd, int rs1, int rs2);
        return {7'b0, REG_IDX_WIDTH'(rs2), REG_IDX_WIDTH'(rs1), 3'b0, REG_IDX_WIDTH'(rd), opc};
    endfunction

    function automatic step_t make_row(string name, logic [DATA_WIDTH-1:0] insn, bit valid,
                                       rob_op_e kind, int erd, bit use1, bit use2, bit fl);
        step_t r;
        r.name      = name;
        r.pc        = $urandom & 32'hffff_fffc;
        r.insn      = insn;
        r.valid     = valid;
        r.rs_stall  = cur_stall;
        r.ready     = cur_ready;
        r.ready_rnd = cur_rnd;
        r.flush     = fl;
        r.kind      = kind;
        r.erd       = REG_IDX_WIDTH'(erd);
        r.use1      = use1;
        r.use2      = use2;
        return r;
    endfunction

    task automatic add_insn(string name, opcode_e opc, int rd, int rs1, int rs2,
                            rob_op_e kind, int erd, bit use1, bit use2);
        table_q.push_back(make_row(name, encode(opc, rd, rs1, rs2), 1'b1, kind, erd,
                                   use1, use2, 1'b0));
    endtask

    task automatic add_idle(string name, int n);
        repeat (n) table_q.push_back(make_row(name, '0, 1'b0, INT, 0, 1'b0, 1'b0, 1'b0));
    endtask

    task automatic build_table();
        int rd;
        cur_ready = 1'b1;
        cur_rnd   = 1'b0;
        cur_stall = 1'b0;
        // One of each major opcode with its ROB kind, rdest and used sources
        add_insn("opimm", OPIMM, 1, 0, 7, INT, 1, 1, 0);
        add_insn("lui", LUI, 2, 9, 9, INT, 2, 0, 0);
        add_insn("auipc", AUIPC, 3, 1, 1, INT, 3, 0, 0);
        add_insn("op", OP, 4, 1, 2, INT, 4, 1, 1);
        add_insn("jal", JAL, 5, 4, 4, BR, 5, 0, 0);
        add_insn("jalr", JALR, 6, 5, 3, BR, 6, 1, 0);
        add_insn("branch", BRANCH, 7, 4, 6, BR, 0, 1, 1);
        add_insn("load", LOAD, 8, 3, 2, LD, 8, 1, 0);
        add_insn("store", STORE, 9, 8, 4, ST, 0, 1, 1);
        add_idle("settle", 4);
        // A writer of x0 still in flight when x0 is read
        add_insn("x0_wr", OPIMM, 0, 0, 0, INT, 0, 1, 0);
        add_insn("x0_src", OP, 10, 0, 0, INT, 10, 1, 1);
        add_insn("dep_busy", OP, 11, 10, 10, INT, 11, 1, 1);
        add_idle("settle", 4);
        add_insn("dep_freed", OP, 12, 10, 11, INT, 12, 1, 1);
        // Older writer of x13 commits while the younger one is in flight
        cur_ready = 1'b0;
        add_insn("old_wr", OPIMM, 13, 0, 0, INT, 13, 1, 0);
        add_insn("young_wr", OPIMM, 13, 0, 0, INT, 13, 1, 0);
        add_idle("hold", 2);
        add_insn("young_busy", OP, 14, 13, 13, INT, 14, 1, 1);
        cur_ready = 1'b1;
        add_idle("drain", 6);
        add_insn("young_freed", OP, 15, 13, 14, INT, 15, 1, 1);
        add_idle("settle", 4);
        // Commit back-pressure fills the ROB until dispatch stalls
        cur_ready = 1'b0;
        for (int i = 0; i < 10; i++) begin
            add_insn("fill", OPIMM, 16 + i, 15 + i, 0, INT, 16 + i, 1, 0);
        end
        cur_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            add_insn("resume", OP, 26 + i, 16 + i, 25, INT, 26 + i, 1, 1);
        end
        add_idle("settle", 6);
        // Reservation station stall holds the RS port
        add_insn("rs_pre", LOAD, 24, 0, 0, LD, 24, 1, 0);
        cur_stall = 1'b1;
        for (int i = 0; i < 3; i++) begin
            add_insn("rs_stall", OP, 25, 24, 24, INT, 25, 1, 1);
        end
        cur_stall = 1'b0;
        add_insn("rs_resume", OP, 25, 24, 24, INT, 25, 1, 1);
        add_idle("settle", 4);
        // Flush with work in flight
        cur_ready = 1'b0;
        add_insn("pre_flush", OPIMM, 20, 0, 0, INT, 20, 1, 0);
        add_insn("pre_flush", OPIMM, 21, 20, 0, INT, 21, 1, 0);
        add_insn("pre_flush", OPIMM, 22, 21, 0, INT, 22, 1, 0);
        table_q.push_back(make_row("flush", '0, 1'b0, INT, 0, 1'b0, 1'b0, 1'b1));
        add_insn("post_flush", OP, 23, 20, 21, INT, 23, 1, 1);
        cur_ready = 1'b1;
        add_idle("settle", 4);
        // Random register fields under random commit back-pressure
        cur_rnd = 1'b1;
        for (int i = 0; i < 16; i++) begin
            rd = int'($urandom % 32);
            add_insn("random_ready", OP, rd, int'($urandom % 32), int'($urandom % 32),
                     INT, rd, 1, 1);
        end
        cur_rnd = 1'b0;
    endtask

    task automatic check_val(string name, string what, logic [31:0] exp, logic [31:0] act);
        chk_cnt++;
        assert (exp === act) else begin
            err_cnt++;
            $display("ERROR %s: %s expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    task automatic clear_model();
        foreach (m_busy[i]) begin
            m_busy[i] = 1'b0;
        end
        m_rob.delete();
        m_tail        = '0;
        m_enq_pending = 1'b0;
        m_slot_valid  = 1'b0;
        m_rs_en       = 1'b0;
    endtask

    task automatic check_outputs(string name);
        check_val(name, "rs_en", 32'(m_rs_en), 32'(rs_en));
        if (m_rs_en) begin
            check_val(name, "rs_opcode", 32'(e_opcode), 32'(rs_opcode));
            check_val(name, "rs_pc", e_pc, rs_pc);
            check_val(name, "rs_insn", e_insn, rs_insn);
            check_val(name, "rs_dst_tag", 32'(e_dst_tag), 32'(rs_dst_tag));
            for (int i = 0; i < 2; i++) begin
                check_val(name, "rs_src_rdy", 32'(e_src_rdy[i]), 32'(rs_src_rdy[i]));
                if (!e_src_rdy[i]) begin
                    check_val(name, "rs_src_tag", 32'(e_src_tag[i]), 32'(rs_src_tag[i]));
                end
            end
        end
        check_val(name, "commit_valid", 32'(m_slot_valid), 32'(commit_valid));
        if (m_slot_valid) begin
            check_val(name, "commit_pc", m_slot.pc, commit_pc);
            check_val(name, "commit_op", 32'(m_slot.op), 32'(commit_op));
            check_val(name, "commit_rdest", 32'(m_slot.rd), 32'(commit_rdest));
            check_val(name, "commit_tag", 32'(m_slot.tag), 32'(commit_tag));
        end
    endtask

    // Drive one row for a clock cycle, predict the model state and check after the edge
    task automatic apply_row(input step_t r);
        logic                     ready;
        logic                     stall;
        logic                     accept;
        logic                     pop;
        logic [ROB_TAG_WIDTH-1:0] offer;
        logic [REG_IDX_WIDTH-1:0] src [2];
        logic                     used [2];
        logic                     rdy [2];
        logic [ROB_TAG_WIDTH-1:0] stag [2];
        rob_entry_t               head;

        ready          = r.ready_rnd ? (($urandom & 1) != 0) : r.ready;
        flush          = r.flush;
        rs_stall       = r.rs_stall;
        commit_ready   = ready;
        dispatch_valid = r.valid;
        dispatch_pc    = r.pc;
        dispatch_insn  = r.insn;

        stall   = (m_rob.size() + int'(m_enq_pending) >= ROB_DEPTH - 1) || r.rs_stall;
        accept  = r.valid && !stall;
        offer   = m_tail + ROB_TAG_WIDTH'(m_enq_pending);
        pop     = (m_rob.size() != 0) && (!m_slot_valid || ready);
        src[0]  = r.insn[19:15];
        src[1]  = r.insn[24:20];
        used[0] = r.use1;
        used[1] = r.use2;
        for (int i = 0; i < 2; i++) begin
            rdy[i]  = !m_busy[src[i]] || !used[i];
            stag[i] = m_tag[src[i]];
        end
        #1;
        check_val(r.name, "dispatch_stall", 32'(stall), 32'(dispatch_stall));

        @(posedge clk);
        if (r.flush) begin
            clear_model();
        end else begin
            if (pop) begin
                head = m_rob.pop_front();
                // Only the newest writer frees the register
                if (m_tag[head.rd] == head.tag) begin
                    m_busy[head.rd] = 1'b0;
                end
                m_slot = head;
            end
            m_slot_valid = pop || (m_slot_valid && !ready);
            if (m_enq_pending) begin
                m_rob.push_back(m_pending);
                m_tail = m_tail + ROB_TAG_WIDTH'(1);
            end
            m_enq_pending = accept;
            if (accept) begin
                e_opcode  = r.insn[6:0];
                e_pc      = r.pc;
                e_insn    = r.insn;
                e_dst_tag = offer;
                e_src_tag = stag;
                e_src_rdy = rdy;
                if (r.erd != '0) begin
                    m_busy[r.erd] = 1'b1;
                end
                m_tag[r.erd] = offer;
                m_pending    = '{pc: r.pc, op: r.kind, rd: r.erd, tag: offer};
            end
            if (!r.rs_stall) begin
                m_rs_en = accept;
            end
        end
        #1;
        check_outputs(r.name);
    endtask

    initial begin
        step_t drain;

        clk            = 1'b0;
        rst_n          = 1'b0;
        flush          = 1'b0;
        rs_stall       = 1'b0;
        dispatch_pc    = '0;
        dispatch_insn  = '0;
        dispatch_valid = 1'b0;
        commit_ready   = 1'b0;
        void'($urandom(34));
        build_table();
        table_ready = 1'b1;
        foreach (m_tag[i]) begin
            m_tag[i] = '0;
        end
        clear_model();

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (table_q[i]) begin
            apply_row(table_q[i]);
        end

        // Let everything in flight retire
        drain = make_row("final_drain", '0, 1'b0, INT, 0, 1'b0, 1'b0, 1'b0);
        while (m_rob.size() != 0 || m_enq_pending || m_slot_valid) begin
            apply_row(drain);
        end

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (5 + 20 * table_q.size()) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/commit_unit.sv ====
/*
 * Retires the ROB head into a one-entry commit slot.
 * The slot is refilled when empty or when i_commit_ready drains it.
 * The map release goes out in the pop cycle, one cycle ahead of o_commit_valid.
 */
`default_nettype none

module commit_unit
    import procyon_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  logic                     i_commit_ready,

    rob_deq_if.consumer              deq,

    // Register map release
    output logic                     o_release_en,
    output logic [REG_IDX_WIDTH-1:0] o_release_rdest,
    output logic [ROB_TAG_WIDTH-1:0] o_release_tag,

    // Retired instruction
    output logic                     o_commit_valid,
    output logic [ADDR_WIDTH-1:0]    o_commit_pc,
    output rob_op_e                  o_commit_op,
    output logic [REG_IDX_WIDTH-1:0] o_commit_rdest,
    output logic [ROB_TAG_WIDTH-1:0] o_commit_tag
);

    logic pop;

    assign pop     = deq.valid && (!o_commit_valid || i_commit_ready);
    assign deq.pop = pop;

    assign o_release_en    = pop;
    assign o_release_rdest = deq.rdest;
    assign o_release_tag   = deq.tag;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            o_commit_valid <= 1'b0;
        end else if (pop) begin
            o_commit_valid <= 1'b1;
        end else if (i_commit_ready) begin
            o_commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            o_commit_pc    <= deq.pc;
            o_commit_op    <= deq.op;
            o_commit_rdest <= deq.rdest;
            o_commit_tag   <= deq.tag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode_rename.sv ====
/*
 * Decode and rename stage, one instruction per cycle.
 * Source readiness is a snapshot taken at acceptance; there is no later wakeup.
 * o_rs_en holds while i_rs_stall is high, the ROB enqueue strobe is a single pulse.
 */
`default_nettype none

module decode_rename
    import procyon_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  logic                     i_rs_stall,

    // Fetch side
    input  logic [ADDR_WIDTH-1:0]    i_dispatch_pc,
    input  logic [DATA_WIDTH-1:0]    i_dispatch_insn,
    input  logic                     i_dispatch_valid,

    input  logic                     i_rob_full,

    // Register map lookup and rename
    output logic [REG_IDX_WIDTH-1:0] o_lookup_rsrc [2],
    input  logic [ROB_TAG_WIDTH-1:0] i_lookup_tag [2],
    input  logic                     i_lookup_busy [2],
    output logic                     o_rename_en,
    output logic [REG_IDX_WIDTH-1:0] o_rename_rdest,
    output logic [ROB_TAG_WIDTH-1:0] o_rename_tag,

    rob_enq_if.producer              enq,

    output logic                     o_dispatch_stall,

    // Reservation station port
    output logic                     o_rs_en,
    output opcode_e                  o_rs_opcode,
    output logic [ADDR_WIDTH-1:0]    o_rs_pc,
    output logic [DATA_WIDTH-1:0]    o_rs_insn,
    output logic [ROB_TAG_WIDTH-1:0] o_rs_dst_tag,
    output logic [ROB_TAG_WIDTH-1:0] o_rs_src_tag [2],
    output logic                     o_rs_src_rdy [2]
);

    opcode_e                  opcode;
    rob_op_e                  rob_op;
    logic [REG_IDX_WIDTH-1:0] rdest;
    logic                     has_rdest;
    logic                     rs1_unused;
    logic                     rs2_unused;
    logic                     src_rdy [2];
    logic                     accept;

    // Instruction fields
    assign opcode           = opcode_e'(i_dispatch_insn[6:0]);
    assign o_lookup_rsrc[0] = i_dispatch_insn[19:15];
    assign o_lookup_rsrc[1] = i_dispatch_insn[24:20];

    // Stores and branches write no register
    assign has_rdest = !(opcode == STORE || opcode == BRANCH);
    assign rdest     = has_rdest ? i_dispatch_insn[11:7] : '0;

    always_comb begin
        case (opcode)
            LOAD:              rob_op = LD;
            STORE:             rob_op = ST;
            BRANCH, JAL, JALR: rob_op = BR;
            default:           rob_op = INT;
        endcase
    end

    // Operands the format does not read count as ready
    assign rs1_unused = opcode inside {LUI, AUIPC, JAL};
    assign rs2_unused = !(opcode inside {OP, BRANCH, STORE});
    assign src_rdy[0] = !i_lookup_busy[0] || rs1_unused;
    assign src_rdy[1] = !i_lookup_busy[1] || rs2_unused;

    assign o_dispatch_stall = i_rob_full || i_rs_stall;
    assign accept           = i_dispatch_valid && !o_dispatch_stall;

    // Rename uses the tag the ROB offers this cycle
    assign o_rename_en    = accept;
    assign o_rename_rdest = rdest;
    assign o_rename_tag   = enq.tag;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            enq.en  <= 1'b0;
            o_rs_en <= 1'b0;
        end else begin
            enq.en <= accept;
            // RS keeps seeing the same request until it stops stalling
            if (!i_rs_stall) begin
                o_rs_en <= accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            enq.pc          <= i_dispatch_pc;
            enq.op          <= rob_op;
            enq.rdest       <= rdest;
            o_rs_opcode     <= opcode;
            o_rs_pc         <= i_dispatch_pc;
            o_rs_insn       <= i_dispatch_insn;
            o_rs_dst_tag    <= enq.tag;
            o_rs_src_tag[0] <= i_lookup_tag[0];
            o_rs_src_tag[1] <= i_lookup_tag[1];
            o_rs_src_rdy[0] <= src_rdy[0];
            o_rs_src_rdy[1] <= src_rdy[1];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dispatch_top.sv ====
/*
 * Dispatch front end: decode and rename, register map, ROB and commit.
 * Accepted instructions commit three cycles later when the ROB is empty
 * and i_commit_ready is high. i_flush discards everything in flight.
 */
`default_nettype none

module dispatch_top
    import procyon_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,
    input  logic                     i_rs_stall,

    input  logic [ADDR_WIDTH-1:0]    i_dispatch_pc,
    input  logic [DATA_WIDTH-1:0]    i_dispatch_insn,
    input  logic                     i_dispatch_valid,
    output logic                     o_dispatch_stall,

    output logic                     o_rs_en,
    output opcode_e                  o_rs_opcode,
    output logic [ADDR_WIDTH-1:0]    o_rs_pc,
    output logic [DATA_WIDTH-1:0]    o_rs_insn,
    output logic [ROB_TAG_WIDTH-1:0] o_rs_dst_tag,
    output logic [ROB_TAG_WIDTH-1:0] o_rs_src_tag [2],
    output logic                     o_rs_src_rdy [2],

    input  logic                     i_commit_ready,
    output logic                     o_commit_valid,
    output logic [ADDR_WIDTH-1:0]    o_commit_pc,
    output rob_op_e                  o_commit_op,
    output logic [REG_IDX_WIDTH-1:0] o_commit_rdest,
    output logic [ROB_TAG_WIDTH-1:0] o_commit_tag
);

    logic [REG_IDX_WIDTH-1:0] lookup_rsrc [2];
    logic [ROB_TAG_WIDTH-1:0] lookup_tag [2];
    logic                     lookup_busy [2];
    logic                     rename_en;
    logic [REG_IDX_WIDTH-1:0] rename_rdest;
    logic [ROB_TAG_WIDTH-1:0] rename_tag;
    logic                     release_en;
    logic [REG_IDX_WIDTH-1:0] release_rdest;
    logic [ROB_TAG_WIDTH-1:0] release_tag;
    logic                     rob_full;

    rob_enq_if enq_bus ();
    rob_deq_if deq_bus ();

    decode_rename u_decode_rename (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_flush          (i_flush),
        .i_rs_stall       (i_rs_stall),
        .i_dispatch_pc    (i_dispatch_pc),
        .i_dispatch_insn  (i_dispatch_insn),
        .i_dispatch_valid (i_dispatch_valid),
        .i_rob_full       (rob_full),
        .o_lookup_rsrc    (lookup_rsrc),
        .i_lookup_tag     (lookup_tag),
        .i_lookup_busy    (lookup_busy),
        .o_rename_en      (rename_en),
        .o_rename_rdest   (rename_rdest),
        .o_rename_tag     (rename_tag),
        .enq              (enq_bus),
        .o_dispatch_stall (o_dispatch_stall),
        .o_rs_en          (o_rs_en),
        .o_rs_opcode      (o_rs_opcode),
        .o_rs_pc          (o_rs_pc),
        .o_rs_insn        (o_rs_insn),
        .o_rs_dst_tag     (o_rs_dst_tag),
        .o_rs_src_tag     (o_rs_src_tag),
        .o_rs_src_rdy     (o_rs_src_rdy)
    );

    register_map u_register_map (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_flush         (i_flush),
        .i_lookup_rsrc   (lookup_rsrc),
        .o_lookup_tag    (lookup_tag),
        .o_lookup_busy   (lookup_busy),
        .i_rename_en     (rename_en),
        .i_rename_rdest  (rename_rdest),
        .i_rename_tag    (rename_tag),
        .i_release_en    (release_en),
        .i_release_rdest (release_rdest),
        .i_release_tag   (release_tag)
    );

    reorder_buffer u_reorder_buffer (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .enq     (enq_bus),
        .deq     (deq_bus),
        .o_full  (rob_full)
    );

    commit_unit u_commit_unit (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_flush         (i_flush),
        .i_commit_ready  (i_commit_ready),
        .deq             (deq_bus),
        .o_release_en    (release_en),
        .o_release_rdest (release_rdest),
        .o_release_tag   (release_tag),
        .o_commit_valid  (o_commit_valid),
        .o_commit_pc     (o_commit_pc),
        .o_commit_op     (o_commit_op),
        .o_commit_rdest  (o_commit_rdest),
        .o_commit_tag    (o_commit_tag)
    );

endmodule

`default_nettype wire

// ==== verilog/procyon_pkg.sv ====
/*
 * Shared widths, ROB sizing and encodings for the dispatch front end.
 * ROB_DEPTH must be a power of two, since the ROB pointers wrap naturally.
 * Only the RV32I major opcodes are listed; funct3 and funct7 are not decoded.
 */
`default_nettype none

package procyon_pkg;

    // Instruction word and PC widths
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;

    // Architectural register index, 32 registers
    localparam int REG_IDX_WIDTH = 5;

    // Reorder buffer sizing, the tag is an entry index
    localparam int ROB_DEPTH     = 8;
    localparam int ROB_TAG_WIDTH = $clog2(ROB_DEPTH);

    // RV32I major opcodes (insn[6:0])
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        OP     = 7'b0110011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    // Kind of operation held in a ROB entry
    typedef enum logic [1:0] {
        INT = 2'b00,
        LD  = 2'b01,
        ST  = 2'b10,
        BR  = 2'b11
    } rob_op_e;

endpackage

`default_nettype wire

// ==== verilog/register_map.sv ====
/*
 * Rename table with a busy bit and a writer tag per architectural register.
 * Lookups read the state before the edge; x0 is never busy.
 * A rename beats a release of the same register in the same cycle.
 */
`default_nettype none

module register_map
    import procyon_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_flush,

    // Source lookup
    input  logic [REG_IDX_WIDTH-1:0] i_lookup_rsrc [2],
    output logic [ROB_TAG_WIDTH-1:0] o_lookup_tag [2],
    output logic                     o_lookup_busy [2],

    // Destination rename from dispatch
    input  logic                     i_rename_en,
    input  logic [REG_IDX_WIDTH-1:0] i_rename_rdest,
    input  logic [ROB_TAG_WIDTH-1:0] i_rename_tag,

    // Release from commit
    input  logic                     i_release_en,
    input  logic [REG_IDX_WIDTH-1:0] i_release_rdest,
    input  logic [ROB_TAG_WIDTH-1:0] i_release_tag
);

    logic [2**REG_IDX_WIDTH-1:0] map_busy;
    logic [ROB_TAG_WIDTH-1:0]    map_tag [2**REG_IDX_WIDTH];
    logic                        release_hit;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_lookup_busy[i] = map_busy[i_lookup_rsrc[i]];
            o_lookup_tag[i]  = map_tag[i_lookup_rsrc[i]];
        end
    end

    // Only the newest writer may clear the entry
    assign release_hit = i_release_en && (map_tag[i_release_rdest] == i_release_tag);

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            map_busy <= '0;
        end else begin
            if (release_hit) begin
                map_busy[i_release_rdest] <= 1'b0;
            end
            // Later assignment, so a same-cycle rename wins
            if (i_rename_en && i_rename_rdest != '0) begin
                map_busy[i_rename_rdest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rename_en) begin
            map_tag[i_rename_rdest] <= i_rename_tag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
/*
 * In-order circular reorder buffer, entries are complete when enqueued.
 * The offered tag already counts the enqueue pending this cycle.
 * full keeps one slot spare for the registered enqueue still in flight.
 */
`default_nettype none

module reorder_buffer
    import procyon_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_flush,

    rob_enq_if.buffer   enq,
    rob_deq_if.buffer   deq,

    output logic        o_full
);

    // Entry storage
    logic [ADDR_WIDTH-1:0]    rob_pc [ROB_DEPTH];
    rob_op_e                  rob_op [ROB_DEPTH];
    logic [REG_IDX_WIDTH-1:0] rob_rdest [ROB_DEPTH];

    logic [ROB_TAG_WIDTH-1:0] head;
    logic [ROB_TAG_WIDTH-1:0] tail;
    logic [ROB_TAG_WIDTH:0]   count;
    logic [ROB_TAG_WIDTH:0]   pending_cnt;

    // Tag for the next enqueue
    assign enq.tag = tail + {{(ROB_TAG_WIDTH-1){1'b0}}, enq.en};

    assign pending_cnt = count + {{ROB_TAG_WIDTH{1'b0}}, enq.en};
    assign o_full      = pending_cnt >= (ROB_TAG_WIDTH+1)'(ROB_DEPTH - 1);

    // Head entry, its index is its tag
    assign deq.valid = (count != '0);
    assign deq.pc    = rob_pc[head];
    assign deq.op    = rob_op[head];
    assign deq.rdest = rob_rdest[head];
    assign deq.tag   = head;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (enq.en) begin
                tail <= tail + 1'b1;
            end
            if (deq.pop) begin
                head <= head + 1'b1;
            end
            count <= count + {{ROB_TAG_WIDTH{1'b0}}, enq.en}
                           - {{ROB_TAG_WIDTH{1'b0}}, deq.pop};
        end
    end

    always_ff @(posedge clk) begin
        if (enq.en) begin
            rob_pc[tail]    <= enq.pc;
            rob_op[tail]    <= enq.op;
            rob_rdest[tail] <= enq.rdest;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rob_if.sv ====
/*
 * ROB enqueue and dequeue buses.
 * On rob_enq_if the tag flows back from the ROB and is valid every cycle.
 * On rob_deq_if pop may only be raised while valid is high.
 */
`default_nettype none

interface rob_enq_if import procyon_pkg::*; ();
    logic                     en;
    logic [ADDR_WIDTH-1:0]    pc;
    rob_op_e                  op;
    logic [REG_IDX_WIDTH-1:0] rdest;
    logic [ROB_TAG_WIDTH-1:0] tag;

    modport producer (output en, pc, op, rdest, input tag);
    modport buffer   (input en, pc, op, rdest, output tag);
endinterface

interface rob_deq_if import procyon_pkg::*; ();
    logic                     valid;
    logic [ADDR_WIDTH-1:0]    pc;
    rob_op_e                  op;
    logic [REG_IDX_WIDTH-1:0] rdest;
    logic [ROB_TAG_WIDTH-1:0] tag;
    logic                     pop;

    modport buffer   (output valid, pc, op, rdest, tag, input pop);
    modport consumer (input valid, pc, op, rdest, tag, output pop);
endinterface

`default_nettype wire
